// File: sources.f
+incdir+hdl
+incdir+bench
hdl/issue_pkg.sv
hdl/issue_queue.sv
hdl/operand_decode.sv
hdl/hazard_check.sv
hdl/pipe_steer.sv
hdl/issue_lanes.sv
hdl/issue_stage.sv
bench/issue_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the issue stage testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sources.f --top-module issue_tb -o issue_sim

out=$(./obj_dir/issue_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "=== PASS ==="

// File: bench/issue_model.svh
queue_entry_t model_q[$];
issue_lane_t  exp_lane0   = '0;
issue_lane_t  exp_lane1   = '0;
logic         exp_swapped = 1'b0;
logic         exp_full    = 1'b0;
int           accepted    = 0;
int           flushed     = 0;

function automatic pipe_class_e class_of(instr_u i);
  logic [`OPCODE_WIDTH-1:0] op;
  op = i.r_form.opcode;
  if (op[5:4] == 2'b10)
    return pipe_memory;
  if (op[5:4] == 2'b11 || op inside {`OP_CMP, `OP_TEST, `OP_CMPI, `OP_TESTI})
    return pipe_branch;
  return pipe_any;
endfunction

function automatic logic reads(instr_u i, logic [`REG_IDX_WIDTH-1:0] r);
  logic [`OPCODE_WIDTH-1:0] op;
  op = i.r_form.opcode;
  case (op[5:4])
    2'b00:   return op != `OP_NOP && (i.r_form.rs == r || i.r_form.rt == r);
    2'b01:   return i.i_form.rs == r;
    2'b10:   return (op == `OP_LW && i.i_form.rs == r) ||
                    (op == `OP_SW && (i.i_form.rs == r || i.i_form.rt == r));
    default: return op == `OP_JR && i.i_form.rs == r;
  endcase
endfunction

// bit 5 flags a written dest.
function automatic logic [5:0] dest_of(instr_u i);
  logic [`OPCODE_WIDTH-1:0] op;
  op = i.r_form.opcode;
  if (op[5:4] == 2'b00 && op != `OP_NOP)
    return {1'b1, i.r_form.rd};
  if (op[5:4] == 2'b01 || op == `OP_LW)
    return {1'b1, i.i_form.rt};
  return 6'd0;
endfunction

// one clock edge of queue and lanes.
task automatic step_model(input logic fl, input logic psh, input queue_entry_t p0,
                          input queue_entry_t p1, input logic ld_v,
                          input logic [`REG_IDX_WIDTH-1:0] ld_d);
  queue_entry_t h0;
  queue_entry_t h1;
  logic [5:0]   d0;
  pipe_class_e  c0;
  pipe_class_e  c1;
  logic         ok0;
  logic         ok1;
  logic         swap;
  exp_lane0   = '0;
  exp_lane1   = '0;
  exp_swapped = 1'b0;
  if (fl) begin
    flushed += model_q.size();
    model_q.delete();
    exp_full = 1'b0;
    return;
  end
  h0  = (model_q.size() > 0) ? model_q[0] : '0;
  h1  = (model_q.size() > 1) ? model_q[1] : '0;
  d0  = dest_of(h0.instr);
  c0  = class_of(h0.instr);
  c1  = class_of(h1.instr);
  ok0 = h0.valid && !(ld_v && (reads(h0.instr, ld_d) || (h1.valid && reads(h1.instr, ld_d))));
  ok1 = ok0 && h1.valid && !(d0[5] && reads(h1.instr, d0[4:0]));
  if (c0 == c1 && c0 != pipe_any)
    ok1 = 1'b0;  // one branch unit, one memory port.
  swap = ok1 ? (c0 == pipe_memory || (c0 == pipe_any && c1 == pipe_branch))
             : ok0 && c0 == pipe_memory;
  if (ok0) begin
    if (swap)
      exp_lane1 = h0;
    else
      exp_lane0 = h0;
    void'(model_q.pop_front());
  end
  if (ok1) begin
    if (swap)
      exp_lane0 = h1;
    else
      exp_lane1 = h1;
    void'(model_q.pop_front());
  end
  exp_swapped = swap;
  if (psh && !exp_full) begin
    if (p0.valid) begin
      model_q.push_back(p0);
      accepted++;
    end
    if (p1.valid) begin
      model_q.push_back(p1);
      accepted++;
    end
  end
  exp_full = model_q.size() > `ISSUE_QUEUE_DEPTH - 2;
endtask

// File: bench/issue_tb.sv
`include "issue_defines.svh"

module issue_tb;
  import issue_pkg::*;

  localparam int PUSH_ATTEMPTS = 600;
  localparam int CYCLE_LIMIT   = PUSH_ATTEMPTS * 4 + 100;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      flush;
  logic                      push;
  queue_entry_t              in_pair0;
  queue_entry_t              in_pair1;
  logic                      load_valid;
  logic [`REG_IDX_WIDTH-1:0] load_dest;
  logic                      full;
  issue_lane_t               lane0;
  issue_lane_t               lane1;
  logic                      swapped;

  logic [31:0] lfsr        = 32'h7f10_4203;
  logic [31:0] pc_next     = 32'h0000_1000;
  logic [5:0]  id_next     = '0;
  int          attempts    = 0;
  int          cycles      = 0;
  int          issued_seen = 0;
  logic        drove_push  = 1'b0;
  logic        checking    = 1'b0;

  `include "issue_model.svh"

  issue_stage i_issue_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .push       (push),
    .in_pair0   (in_pair0),
    .in_pair1   (in_pair1),
    .load_valid (load_valid),
    .load_dest  (load_dest),
    .full       (full),
    .lane0      (lane0),
    .lane1      (lane1),
    .swapped    (swapped)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // galois lfsr, one step per bit.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic logic [5:0] pick_opcode(logic [3:0] k);
    case (k)
      4'd0, 4'd1:   return 6'h01;  // reg alu.
      4'd2:         return 6'h35;  // other control.
      4'd3, 4'd4:   return 6'h12;  // imm alu.
      4'd5:         return `OP_CMP;
      4'd6:         return `OP_TEST;
      4'd7:         return `OP_CMPI;
      4'd8:         return `OP_TESTI;
      4'd9, 4'd10:  return `OP_LW;
      4'd11, 4'd12: return `OP_SW;
      4'd13:        return `OP_JR;
      4'd14:        return 6'h2b;
      default:      return `OP_NOP;
    endcase
  endfunction

  // registers 0..3 only, so dependences are common.
  function automatic queue_entry_t make_entry(logic v);
    queue_entry_t e;
    e.valid               = v;
    e.pc                  = pc_next;
    e.id                  = id_next;
    e.instr.r_form.opcode = pick_opcode(4'(rand_bits(4)));
    e.instr.r_form.rs     = 5'(rand_bits(2));
    e.instr.r_form.rt     = 5'(rand_bits(2));
    e.instr.r_form.rd     = 5'(rand_bits(2));
    e.instr.r_form.unused = 11'(rand_bits(11));
    if (v) begin
      pc_next = pc_next + 32'd4;
      id_next = id_next + 6'd1;
    end
    return e;
  endfunction

  task automatic drive_next();
    drove_push = 1'b0;
    load_valid <= rand_bits(2) == 32'd3;
    load_dest  <= 5'(rand_bits(2));
    flush      <= attempts < PUSH_ATTEMPTS && rand_bits(6) == 32'd0;
    if (attempts < PUSH_ATTEMPTS && !exp_full && rand_bits(2) != 32'd0) begin
      push       <= 1'b1;
      in_pair0   <= make_entry(rand_bits(2) != 32'd0);
      in_pair1   <= make_entry(rand_bits(2) != 32'd0);
      attempts++;
      drove_push = 1'b1;
    end else begin
      push <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_lane(input string name, input issue_lane_t got, input issue_lane_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp))
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  // outputs settle well before the falling edge.
  always @(negedge clk) begin
    if (checking) begin
      check_lane("lane0", lane0, exp_lane0);
      check_lane("lane1", lane1, exp_lane1);
      check_bit("swapped", swapped, exp_swapped);
      check_bit("full", full, exp_full);
      issued_seen += int'(lane0.valid) + int'(lane1.valid);
    end
  end

  initial begin
    rst_n      = 1'b0;
    flush      = 1'b0;
    push       = 1'b0;
    in_pair0   = '0;
    in_pair1   = '0;
    load_valid = 1'b0;
    load_dest  = '0;
    repeat (3) @(posedge clk);
    rst_n    <= 1'b1;
    checking <= 1'b1;
    while (attempts < PUSH_ATTEMPTS || drove_push || model_q.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > CYCLE_LIMIT)
        fail_run($sformatf("timeout: queue not drained within %0d cycles", CYCLE_LIMIT));
      step_model(flush, push, in_pair0, in_pair1, load_valid, load_dest);
      drive_next();
    end
    @(negedge clk);
    @(posedge clk);
    check_count("issued", issued_seen, accepted - flushed);  // every survivor issued once.
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: hdl/issue_stage.sv
`include "issue_defines.svh"

module issue_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  logic                      push,
  input  issue_pkg::queue_entry_t   in_pair0,
  input  issue_pkg::queue_entry_t   in_pair1,
  input  logic                      load_valid,
  input  logic [`REG_IDX_WIDTH-1:0] load_dest,
  output logic                      full,
  output issue_pkg::issue_lane_t    lane0,
  output issue_pkg::issue_lane_t    lane1,
  output logic                      swapped
);
  import issue_pkg::*;

  queue_entry_t head0;
  queue_entry_t head1;
  slot_info_t   info0;
  slot_info_t   info1;
  logic [1:0]   ok_mask;
  logic [1:0]   issue_mask;
  logic         swap;

  //////////////////////////////////////////////////
  // queue
  //////////////////////////////////////////////////

  issue_queue i_queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .push     (push),
    .in_pair0 (in_pair0),
    .in_pair1 (in_pair1),
    .pop_mask (issue_mask),  // popped as issued.
    .head0    (head0),
    .head1    (head1),
    .full     (full)
  );

  //////////////////////////////////////////////////
  // decode, hazards, steering
  //////////////////////////////////////////////////

  operand_decode i_decode0 (
    .instr (head0.instr),
    .info  (info0)
  );

  operand_decode i_decode1 (
    .instr (head1.instr),
    .info  (info1)
  );

  hazard_check i_hazard (
    .head_valid ({head1.valid, head0.valid}),
    .slot0      (info0),
    .slot1      (info1),
    .load_valid (load_valid),
    .load_dest  (load_dest),
    .ok_mask    (ok_mask)
  );

  pipe_steer i_steer (
    .slot0      (info0),
    .slot1      (info1),
    .ok_mask    (ok_mask),
    .issue_mask (issue_mask),
    .swap       (swap)
  );

  issue_lanes i_lanes (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .head0      (head0),
    .head1      (head1),
    .issue_mask (issue_mask),
    .swap       (swap),
    .lane0      (lane0),
    .lane1      (lane1),
    .swapped    (swapped)
  );

endmodule

// File: hdl/issue_lanes.sv
`include "issue_defines.svh"

module issue_lanes (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  issue_pkg::queue_entry_t head0,
  input  issue_pkg::queue_entry_t head1,
  input  logic [1:0]              issue_mask,
  input  logic                    swap,
  output issue_pkg::issue_lane_t  lane0,
  output issue_pkg::issue_lane_t  lane1,
  output logic                    swapped
);
  import issue_pkg::*;

  issue_lane_t lane0_q;
  issue_lane_t lane1_q;
  logic [1:0]  lane_vld;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      lane_vld <= 2'b00;
      swapped  <= 1'b0;
    end else begin
      lane_vld[0] <= swap ? issue_mask[1] : issue_mask[0];
      lane_vld[1] <= swap ? issue_mask[0] : issue_mask[1];
      swapped     <= swap;
    end
  end

  always_ff @(posedge clk) begin
    lane0_q <= swap ? head1 : head0;
    lane1_q <= swap ? head0 : head1;
  end

  always_comb begin
    lane0       = lane0_q;
    lane0.valid = lane_vld[0];
    lane1       = lane1_q;
    lane1.valid = lane_vld[1];
  end

  a_lane0_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
    lane0.valid |-> lane0.instr.r_form.opcode[`OPCODE_WIDTH-1 -: 2] != `OP_CLASS_MEM)
    else $error("issue_lanes: memory op on lane 0");

  a_lane1_no_branch: assert property (@(posedge clk) disable iff (!rst_n)
    lane1.valid |-> !(lane1.instr.r_form.opcode[`OPCODE_WIDTH-1 -: 2] == `OP_CLASS_CTRL ||
                      lane1.instr.r_form.opcode inside {`OP_CMP, `OP_TEST, `OP_CMPI, `OP_TESTI}))
    else $error("issue_lanes: branch op on lane 1");

endmodule

// File: hdl/pipe_steer.sv
module pipe_steer (
  input  issue_pkg::slot_info_t slot0,
  input  issue_pkg::slot_info_t slot1,
  input  logic [1:0]            ok_mask,
  output logic [1:0]            issue_mask,
  output logic                  swap
);
  import issue_pkg::*;

  pipe_class_e c0;
  pipe_class_e c1;
  logic        lane_conflict;

  assign c0 = slot0.pipe;
  assign c1 = slot1.pipe;

  // one branch unit, one memory port.
  assign lane_conflict = (c0 == c1) && (c0 != pipe_any);
  assign issue_mask    = lane_conflict ? (ok_mask & 2'b01) : ok_mask;

  //////////////////////////////////////////////////
  // lane mapping
  //////////////////////////////////////////////////

  // swap puts slot 0 on lane 1.
  always_comb begin
    case (issue_mask)
      2'b11:   swap = (c0 == pipe_memory) || (c0 == pipe_any && c1 == pipe_branch);
      2'b01:   swap = (c0 == pipe_memory);
      default: swap = 1'b0;
    endcase
  end

  always_comb begin
    a_in_order: assert final (issue_mask != 2'b10)
      else $error("pipe_steer: slot 1 issued without slot 0");
  end

endmodule

// File: hdl/hazard_check.sv
`include "issue_defines.svh"

module hazard_check (
  input  logic [1:0]                head_valid,
  input  issue_pkg::slot_info_t     slot0,
  input  issue_pkg::slot_info_t     slot1,
  input  logic                      load_valid,
  input  logic [`REG_IDX_WIDTH-1:0] load_dest,
  output logic [1:0]                ok_mask
);
  import issue_pkg::*;

  logic load_stall;
  logic pair_dep;

  function automatic logic reads_reg(slot_info_t s, logic [`REG_IDX_WIDTH-1:0] r);
    return (s.use_src0 && s.src0 == r) || (s.use_src1 && s.src1 == r);
  endfunction

  // load result not back yet, hold the whole pair.
  assign load_stall = load_valid &&
                      ((head_valid[0] && reads_reg(slot0, load_dest)) ||
                       (head_valid[1] && reads_reg(slot1, load_dest)));

  // slot 1 needs slot 0's result.
  assign pair_dep = slot0.use_dest && reads_reg(slot1, slot0.dest);

  assign ok_mask[0] = head_valid[0] && !load_stall;
  assign ok_mask[1] = ok_mask[0] && head_valid[1] && !pair_dep;  // never ahead of slot 0.

endmodule

// File: hdl/operand_decode.sv
`include "issue_defines.svh"

module operand_decode (
  input  issue_pkg::instr_u     instr,
  output issue_pkg::slot_info_t info
);
  import issue_pkg::*;

  logic [`OPCODE_WIDTH-1:0] op;

  assign op = instr.r_form.opcode;

  always_comb begin
    info      = '0;
    info.pipe = pipe_any;
    case (op[`OPCODE_WIDTH-1 -: 2])
      `OP_CLASS_REG: begin
        if (op != `OP_NOP) begin
          info.src0     = instr.r_form.rs;
          info.src1     = instr.r_form.rt;
          info.dest     = instr.r_form.rd;
          info.use_src0 = 1'b1;
          info.use_src1 = 1'b1;
          info.use_dest = 1'b1;
        end
        if (op == `OP_CMP || op == `OP_TEST) begin
          info.pipe = pipe_branch;  // flags feed the branch unit.
        end
      end
      `OP_CLASS_IMM: begin
        info.src0     = instr.i_form.rs;
        info.dest     = instr.i_form.rt;
        info.use_src0 = 1'b1;
        info.use_dest = 1'b1;
        if (op == `OP_CMPI || op == `OP_TESTI) begin
          info.pipe = pipe_branch;
        end
      end
      `OP_CLASS_MEM: begin
        info.pipe = pipe_memory;
        if (op == `OP_LW) begin
          info.src0     = instr.i_form.rs;
          info.dest     = instr.i_form.rt;
          info.use_src0 = 1'b1;
          info.use_dest = 1'b1;
        end else if (op == `OP_SW) begin
          info.src0     = instr.i_form.rs;
          info.src1     = instr.i_form.rt;  // store data.
          info.use_src0 = 1'b1;
          info.use_src1 = 1'b1;
        end
      end
      `OP_CLASS_CTRL: begin
        info.pipe = pipe_branch;
        if (op == `OP_JR) begin
          info.src0     = instr.i_form.rs;
          info.use_src0 = 1'b1;
        end
      end
    endcase
  end

endmodule

// File: hdl/issue_queue.sv
`include "issue_defines.svh"

module issue_queue (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,
  input  logic                    push,
  input  issue_pkg::queue_entry_t in_pair0,
  input  issue_pkg::queue_entry_t in_pair1,
  input  logic [1:0]              pop_mask,
  output issue_pkg::queue_entry_t head0,
  output issue_pkg::queue_entry_t head1,
  output logic                    full
);
  import issue_pkg::*;

  localparam int DEPTH = `ISSUE_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  queue_entry_t     mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr_nx;
  logic [PTR_W-1:0] wr_ptr_nx;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   count_nx;
  logic [PTR_W:0]   push_n;
  logic [PTR_W:0]   pop_n;
  logic             accept;
  queue_entry_t     wr_first;
  queue_entry_t     wr_second;

  assign accept    = push && !full && !flush;
  assign push_n    = accept ? (PTR_W+1)'(in_pair0.valid) + (PTR_W+1)'(in_pair1.valid) : '0;
  assign pop_n     = (PTR_W+1)'(pop_mask[0]) + (PTR_W+1)'(pop_mask[1]);
  assign count_nx  = count + push_n - pop_n;
  assign rd_ptr_nx = rd_ptr + PTR_W'(1);
  assign wr_ptr_nx = wr_ptr + PTR_W'(1);

  // lone slot 1 moves up.
  assign wr_first  = in_pair0.valid ? in_pair0 : in_pair1;
  assign wr_second = in_pair1;

  //////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
    end else begin
      rd_ptr <= rd_ptr + pop_n[PTR_W-1:0];
      wr_ptr <= wr_ptr + push_n[PTR_W-1:0];
      count  <= count_nx;
      full   <= count_nx > (PTR_W+1)'(DEPTH - 2);  // under two free.
    end
  end

  always_ff @(posedge clk) begin
    if (push_n != '0) begin
      mem[wr_ptr] <= wr_first;
    end
    if (push_n == (PTR_W+1)'(2)) begin
      mem[wr_ptr_nx] <= wr_second;
    end
  end

  assign head0 = (count != '0) ? mem[rd_ptr] : '0;
  assign head1 = (count > (PTR_W+1)'(1)) ? mem[rd_ptr_nx] : '0;

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    !(push && full))
    else $error("issue_queue: push while full");

  a_pop_in_range: assert property (@(posedge clk) disable iff (!rst_n || flush)
    pop_n <= count)
    else $error("issue_queue: pop beyond queue count");

endmodule

// File: hdl/issue_pkg.sv
`include "issue_defines.svh"

package issue_pkg;

  // register-register view.
  typedef struct packed {
    logic [`OPCODE_WIDTH-1:0]                                   opcode;
    logic [`REG_IDX_WIDTH-1:0]                                  rs;
    logic [`REG_IDX_WIDTH-1:0]                                  rt;
    logic [`REG_IDX_WIDTH-1:0]                                  rd;
    logic [`INST_WIDTH-`OPCODE_WIDTH-3*`REG_IDX_WIDTH-1:0]      unused;
  } r_form_t;

  // immediate view, rt is the dest here.
  typedef struct packed {
    logic [`OPCODE_WIDTH-1:0]                                   opcode;
    logic [`REG_IDX_WIDTH-1:0]                                  rs;
    logic [`REG_IDX_WIDTH-1:0]                                  rt;
    logic [`INST_WIDTH-`OPCODE_WIDTH-2*`REG_IDX_WIDTH-1:0]      imm;
  } i_form_t;

  typedef union packed {
    r_form_t r_form;
    i_form_t i_form;
  } instr_u;

  typedef struct packed {
    logic                       valid;
    logic [`ADDR_WIDTH-1:0]     pc;
    logic [`INSTR_ID_WIDTH-1:0] id;
    instr_u                     instr;
  } queue_entry_t;

  typedef queue_entry_t issue_lane_t;

  typedef enum logic [1:0] {
    pipe_any,
    pipe_branch,
    pipe_memory
  } pipe_class_e;

  typedef struct packed {
    logic [`REG_IDX_WIDTH-1:0] src0;
    logic [`REG_IDX_WIDTH-1:0] src1;
    logic [`REG_IDX_WIDTH-1:0] dest;
    logic                      use_src0;
    logic                      use_src1;
    logic                      use_dest;
    pipe_class_e               pipe;
  } slot_info_t;

endpackage

// File: hdl/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

//////////////////////////////////////////////////
// widths and sizes
//////////////////////////////////////////////////

`define ISSUE_QUEUE_DEPTH 8
`define INST_WIDTH        32
`define ADDR_WIDTH        32
`define INSTR_ID_WIDTH    6
`define REG_IDX_WIDTH     5   // 32 registers.
`define OPCODE_WIDTH      6

//////////////////////////////////////////////////
// opcodes
//////////////////////////////////////////////////

`define OP_CLASS_REG  2'b00  // register alu.
`define OP_CLASS_IMM  2'b01  // immediate alu.
`define OP_CLASS_MEM  2'b10
`define OP_CLASS_CTRL 2'b11  // jumps.

`define OP_NOP   6'h00
`define OP_CMP   6'h0c
`define OP_TEST  6'h0d
`define OP_CMPI  6'h1c
`define OP_TESTI 6'h1d
`define OP_LW    6'h20
`define OP_SW    6'h21
`define OP_JR    6'h30

`endif
